// ==== qsic_patterns.txt ====
# T name starts a test, X pulses reset, W/R: bs7 addr(octal) data(hex), N: bs7 addr(octal)
# M: dev_sel block(hex) dev_ready(hex) lba(hex) loaded(hex) device
T idle_after_reset
X
R 1 17700 0000
R 1 17702 0000
R 1 17704 0000
R 1 17706 0000
R 1 17710 0000
R 1 17712 0000
R 1 17714 0000
R 1 17716 0000
T write_read_back
W 1 17700 8001
W 1 17702 a002
W 1 17704 4003
W 1 17706 ffff
W 1 17710 c010
W 1 17712 0abc
W 1 17714 8100
W 1 17716 b000
R 1 17700 8001
R 1 17702 a002
R 1 17704 4003
R 1 17706 ffff
R 1 17710 c010
R 1 17712 0abc
R 1 17714 8100
R 1 17716 b000
T no_reply_outside
N 1 17720
N 0 17700
N 1 17676
T block_mapping
M 0 0005 f 00002005 db 0
M 3 0123 f 03ffe123 db 3
M 7 0abc f 02000abc db 1
T loaded_bits
M 1 1fff 1 00005fff 41 1
M 6 0000 2 00200000 82 0
M 4 0000 4 00020000 10 2
M 2 0001 8 00006001 08 2
M 0 0000 3 00002000 c3 0
M 5 0010 0 01578010 00 0
T reset_mid_use
X
R 1 17700 0000
R 1 17716 0000
M 3 0000 f 00000000 00 0

// ==== qsic_top.f ====
+incdir+.
qsic_pkg.sv
qbus_decode.sv
qbus_cycle.sv
pack_table.sv
qsic_top.sv
tb_qsic.sv

// ==== Makefile ====
# Verilator lint and simulation of the QBUS load-table slave
# run from the project root; the testbench reads qsic_patterns.txt from here

VERILATOR ?= verilator
TOP       ?= tb_qsic
FILELIST  ?= qsic_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
FAIL_MSG  ?= TEST FAILED
VFLAGS    ?= --timing --assert
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j 0 --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_qsic_tasks.svh ====
/* QBUS master tasks for tb_qsic, working on its signals directly
   every wait is bounded and a missing reply counts as an error */

// wrong value, with time
task automatic report_mismatch(input string msg);
   $display("MISMATCH at %0t: %s", $time, msg);
   errors++;
   test_errors++;
endtask

task automatic report_error(input string msg);
   $display("error at %0t: %s", $time, msg);
   errors++;
   test_errors++;
endtask

// closes the running test with one line
task automatic finish_test();
   if (test_name.len() > 0) begin
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s passed", test_name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", test_name, test_errors);
      end
   end
   test_errors = 0;
endtask

// 4 clocks of reset, strobes parked
task automatic apply_reset();
   reset <= 1'b1;
   sync  <= 1'b0;
   din   <= 1'b0;
   dout  <= 1'b0;
   repeat (4) @(posedge clk20);
   reset <= 1'b0;
endtask

task automatic check_reset_state();
   @(negedge clk20);
   if (trply !== 1'b0 || dal_tx !== 1'b0 || dal_st !== 1'b0) begin
      report_mismatch("reply or transceiver enable active after reset");
   end
   if (dal_be_l !== 1'b1) begin
      report_mismatch("dal_be_l low after reset");
   end
   if (tdal !== '0) begin
      report_mismatch($sformatf("tdal %h after reset, expected 0", tdal));
   end
endtask

// address phase, held 4 clocks past sync
task automatic start_cycle(input logic bs7_v, input dal_t addr);
   @(posedge clk20);
   dal_in <= addr;
   bs7    <= bs7_v;
   sync   <= 1'b1;
   repeat (4) @(posedge clk20);
endtask

// seen stays low on timeout
task automatic wait_reply(output logic seen);
   int n;
   n    = 0;
   seen = 1'b0;
   while (!seen && n < timeout_cycles) begin
      @(negedge clk20);
      seen = (trply === 1'b1);
      n++;
   end
endtask

// drop din/dout, wait for the slave to let go, then end the cycle
task automatic release_cycle(input string what);
   int n;
   n = 0;
   @(posedge clk20);
   din  <= 1'b0;
   dout <= 1'b0;
   do begin
      @(negedge clk20);
      n++;
   end while ((trply || dal_tx || dal_st || !dal_be_l) && n < release_cycles);
   if (trply || dal_tx || dal_st || !dal_be_l) begin
      report_error({what, ": slave still driving after the master dropped its strobe"});
   end
   @(posedge clk20);
   sync   <= 1'b0;
   bs7    <= 1'b0;
   dal_in <= '0;
   repeat (2) @(posedge clk20);   // idle gap so sync is seen low
endtask

task automatic bus_write(input logic bs7_v, input dal_t addr, input word_t data);
   logic seen;
   start_cycle(bs7_v, addr);
   dal_in <= {6'b0, data};   // data phase
   dout   <= 1'b1;
   wait_reply(seen);
   if (!seen) begin
      report_error($sformatf("no reply to write at %o within %0d cycles", addr,
                             timeout_cycles));
   end
   release_cycle("write");
endtask

task automatic bus_read(input logic bs7_v, input dal_t addr, input word_t expected);
   logic seen;
   start_cycle(bs7_v, addr);
   din <= 1'b1;
   wait_reply(seen);
   if (!seen) begin
      report_error($sformatf("no reply to read at %o within %0d cycles", addr,
                             timeout_cycles));
   end else begin
      if (tdal !== {6'b0, expected}) begin
         report_mismatch($sformatf("read at %o gave %h, expected %h", addr, tdal,
                                   {6'b0, expected}));
      end
      if (dal_tx !== 1'b1 || dal_st !== 1'b1 || dal_be_l !== 1'b0) begin
         report_mismatch("transceiver controls not driving while trply is high");
      end
   end
   release_cycle("read");
endtask

// read outside the table, nothing may answer
task automatic check_no_reply(input logic bs7_v, input dal_t addr);
   logic replied;
   logic driven;
   replied = 1'b0;
   driven  = 1'b0;
   start_cycle(bs7_v, addr);
   din <= 1'b1;
   for (int n = 0; n < no_reply_cycles; n++) begin
      @(negedge clk20);
      if (trply !== 1'b0) begin
         replied = 1'b1;
      end
      if (tdal !== '0) begin
         driven = 1'b1;
      end
   end
   if (replied) begin
      report_error($sformatf("reply to address %o, bs7 %b, outside the table", addr, bs7_v));
   end
   if (driven) begin
      report_mismatch($sformatf("tdal driven for address %o outside the table", addr));
   end
   release_cycle("read outside table");
endtask

task automatic check_mapping(input dev_sel_t sel, input block_t blk, input logic [3:0] rdy,
                             input lba_t exp_lba, input logic [7:0] exp_loaded,
                             input device_t exp_dev);
   @(posedge clk20);
   dev_sel   <= sel;
   block     <= blk;
   dev_ready <= rdy;
   @(negedge clk20);   // outputs are combinational
   if (lba !== exp_lba) begin
      report_mismatch($sformatf("drive %0d block %h: lba %h, expected %h", sel, blk, lba,
                                exp_lba));
   end
   if (loaded !== exp_loaded) begin
      report_mismatch($sformatf("ready %b: loaded %h, expected %h", rdy, loaded, exp_loaded));
   end
   if (pack_device !== exp_dev) begin
      report_mismatch($sformatf("drive %0d: device %0d, expected %0d", sel, pack_device,
                                exp_dev));
   end
endtask

// ==== tb_qsic.sv ====
/* run from the project root so qsic_patterns.txt is found
   inputs change after the rising edge, checks sample at the falling edge */
`default_nettype none

module tb_qsic import qsic_pkg::*; ();

   localparam string pattern_file    = "qsic_patterns.txt";
   localparam int    timeout_cycles  = 50;   // limit on any reply wait
   localparam int    no_reply_cycles = 20;   // window for addresses outside the table
   localparam int    release_cycles  = 4;    // controls gone by then

   logic       clk20;
   logic       reset;
   logic       sync;
   logic       din;
   logic       dout;
   logic       bs7;
   dal_t       dal_in;
   dev_sel_t   dev_sel;
   block_t     block;
   logic [3:0] dev_ready;

   logic       trply;
   logic       dal_tx;
   logic       dal_st;
   logic       dal_be_l;
   dal_t       tdal;
   lba_t       lba;
   logic [7:0] loaded;
   device_t    pack_device;

   int         errors;         // whole run
   int         test_errors;    // current test only
   int         tests_run;
   int         tests_failed;
   string      test_name;

   qsic_top UUT (
      .clk20       (clk20),
      .reset       (reset),
      .sync        (sync),
      .din         (din),
      .dout        (dout),
      .bs7         (bs7),
      .dal_in      (dal_in),
      .dev_sel     (dev_sel),
      .block       (block),
      .dev_ready   (dev_ready),
      .trply       (trply),
      .dal_tx      (dal_tx),
      .dal_st      (dal_st),
      .dal_be_l    (dal_be_l),
      .tdal        (tdal),
      .lba         (lba),
      .loaded      (loaded),
      .pack_device (pack_device)
   );

   `include "tb_qsic_tasks.svh"

   // 100 unit period
   initial begin
      clk20 = 1'b0;
      forever #50 clk20 = ~clk20;
   end

   initial begin
      int          fd;
      int          n;
      string       line;
      byte         op;
      logic [31:0] b7;
      logic [31:0] sel;
      logic [31:0] dev;
      dal_t        addr;
      word_t       val;
      block_t      blk;
      logic [3:0]  rdy;
      lba_t        exp_lba;
      logic [7:0]  exp_loaded;

      reset        = 1'b1;
      sync         = 1'b0;
      din          = 1'b0;
      dout         = 1'b0;
      bs7          = 1'b0;
      dal_in       = '0;
      dev_sel      = '0;
      block        = '0;
      dev_ready    = '0;
      errors       = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_name    = "";

      apply_reset();

      fd = $fopen(pattern_file, "r");
      if (fd == 0) begin
         $display("cannot open pattern file %s", pattern_file);
         errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
               continue;   // blank or column notes
            end
            op = line[0];
            n  = 0;
            case (op)
               "T": begin
                  finish_test();
                  n = $sscanf(line, "T %s", test_name);
               end
               "X": begin
                  @(posedge clk20);
                  apply_reset();
                  check_reset_state();
                  n = 1;
               end
               "W": begin
                  n = $sscanf(line, "W %d %o %h", b7, addr, val);
                  if (n == 3) begin
                     bus_write(b7[0], addr, val);
                  end
               end
               "R": begin
                  n = $sscanf(line, "R %d %o %h", b7, addr, val);
                  if (n == 3) begin
                     bus_read(b7[0], addr, val);
                  end
               end
               "N": begin
                  n = $sscanf(line, "N %d %o", b7, addr);
                  if (n == 2) begin
                     check_no_reply(b7[0], addr);
                  end
               end
               "M": begin
                  n = $sscanf(line, "M %d %h %h %h %h %d", sel, blk, rdy, exp_lba,
                              exp_loaded, dev);
                  if (n == 6) begin
                     check_mapping(sel[2:0], blk, rdy, exp_lba, exp_loaded, dev[1:0]);
                  end
               end
               default: n = 0;
            endcase
            if (n == 0 || (op == "W" && n != 3) || (op == "R" && n != 3) ||
                (op == "N" && n != 2) || (op == "M" && n != 6)) begin
               report_error($sformatf("cannot parse pattern line: %s", line));
            end
         end
         $fclose(fd);
      end

      finish_test();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_run > 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== qsic_top.sv ====
/* QBUS slave for the load table at 17700..17716, bs7 set
   dal and bs7 come as separate in/out ports; reset stands in for bus INIT */
`default_nettype none

module qsic_top import qsic_pkg::*; #(
   parameter int settle_cycles = 2    // read settle delay, see qbus_cycle
) (
   input  logic               clk20,
   input  logic               reset,
   input  logic               sync,
   input  logic               din,
   input  logic               dout,
   input  logic               bs7,
   input  dal_t               dal_in,
   input  dev_sel_t           dev_sel,
   input  block_t             block,
   input  logic [3:0]         dev_ready,
   output logic               trply,
   output logic               dal_tx,
   output logic               dal_st,
   output logic               dal_be_l,
   output dal_t               tdal,
   output lba_t               lba,
   output logic [n_packs-1:0] loaded,
   output device_t            pack_device
);

   bus_req_t   req;        // decode to cycle, every clock
   word_t      rd_word;    // table word at req.index
   logic       wr_stb;
   logic [2:0] wr_index;
   word_t      wr_data;

   qbus_decode u_decode (
      .clk20  (clk20),
      .reset  (reset),
      .sync   (sync),
      .din    (din),
      .dout   (dout),
      .bs7    (bs7),
      .dal_in (dal_in),
      .req    (req)
   );

   qbus_cycle #(
      .settle_cycles (settle_cycles)
   ) u_cycle (
      .clk20    (clk20),
      .reset    (reset),
      .req      (req),
      .rd_word  (rd_word),
      .dal_in   (dal_in),
      .trply    (trply),
      .dal_tx   (dal_tx),
      .dal_st   (dal_st),
      .dal_be_l (dal_be_l),
      .tdal     (tdal),
      .wr_stb   (wr_stb),
      .wr_index (wr_index),
      .wr_data  (wr_data)
   );

   pack_table u_table (
      .clk20       (clk20),
      .reset       (reset),
      .wr_stb      (wr_stb),
      .wr_index    (wr_index),
      .wr_data     (wr_data),
      .rd_index    (req.index),   // read port follows the bus address
      .dev_sel     (dev_sel),
      .block       (block),
      .dev_ready   (dev_ready),
      .rd_word     (rd_word),
      .lba         (lba),
      .loaded      (loaded),
      .pack_device (pack_device)
   );

endmodule

`default_nettype wire

// ==== pack_table.sv ====
/* eight load-table words, cleared by reset and written one word per strobe
   lba and loaded are combinational from dev_sel, block and dev_ready */
`default_nettype none

module pack_table import qsic_pkg::*; (
   input  logic               clk20,
   input  logic               reset,
   input  logic               wr_stb,
   input  logic [2:0]         wr_index,
   input  word_t              wr_data,
   input  logic [2:0]         rd_index,
   input  dev_sel_t           dev_sel,
   input  block_t             block,
   input  logic [3:0]         dev_ready,   // one per device code
   output word_t              rd_word,
   output lba_t               lba,
   output logic [n_packs-1:0] loaded,
   output device_t            pack_device
);

   pack_entry_t table_q [n_packs];
   pack_entry_t sel;      // entry of the selected drive

   always_ff @(posedge clk20) begin
      if (reset) begin
         for (int i = 0; i < n_packs; i++) begin
            table_q[i] <= '0;   // all packs unloaded
         end
      end else if (wr_stb) begin
         table_q[wr_index] <= pack_entry_t'(wr_data);
      end
   end

   assign rd_word = word_t'(table_q[rd_index]);   // bus view of the word

   assign sel         = table_q[dev_sel];
   assign pack_device = sel.device;

   // pack start plus block within the pack
   assign lba = lba_t'(block) + (lba_t'(sel.offset) << offset_shift);

   // loaded means enabled and its backing device ready
   always_comb begin
      for (int i = 0; i < n_packs; i++) begin
         loaded[i] = table_q[i].enable & dev_ready[table_q[i].device];
      end
   end

endmodule

`default_nettype wire

// ==== qbus_cycle.sv ====
/* one slave cycle at a time; master keeps din/dout until it sees trply
   read reply comes settle_cycles after dal_tx so the transceivers can settle */
`default_nettype none

module qbus_cycle import qsic_pkg::*; #(
   parameter int settle_cycles = 2    // extra din cycles before reply
) (
   input  logic       clk20,
   input  logic       reset,
   input  bus_req_t   req,
   input  word_t      rd_word,
   input  dal_t       dal_in,
   output logic       trply,
   output logic       dal_tx,
   output logic       dal_st,
   output logic       dal_be_l,
   output dal_t       tdal,
   output logic       wr_stb,
   output logic [2:0] wr_index,
   output word_t      wr_data
);

   localparam int cnt_w = (settle_cycles > 0) ? $clog2(settle_cycles + 1) : 1;

   typedef enum logic [1:0] {
      idle,
      read_drive,    // transceivers toward the bus while data settles
      read_reply,    // data latched and enabled with reply up
      write_reply    // word taken and reply held until dout drops
   } state_t;

   state_t           state;
   state_t           state_nx;
   logic [cnt_w-1:0] settle_cnt;
   logic             settle_done;
   logic             write_start;
   logic             wrote_q;       // strobe already given in this sync cycle

   assign settle_done = (int'(settle_cnt) + 1 >= settle_cycles);
   assign write_start = (state == idle) && (state_nx == write_reply);

   always_comb begin
      state_nx = state;
      case (state)
         idle: begin
            if (req.hit && req.din_s) begin
               state_nx = (settle_cycles == 0) ? read_reply : read_drive;
            end else if (req.hit && req.dout_rise) begin
               state_nx = write_reply;
            end
         end
         read_drive: begin
            if (!req.din_s || !req.hit) begin
               state_nx = idle;          // master gave up
            end else if (req.din_late && settle_done) begin
               state_nx = read_reply;
            end
         end
         read_reply: begin
            if (!req.din_s || !req.hit) state_nx = idle;
         end
         write_reply: begin
            if (!req.dout_s || !req.hit) state_nx = idle;
         end
         default: state_nx = idle;
      endcase
   end

   always_ff @(posedge clk20) begin
      if (reset) begin
         state <= idle;
      end else begin
         state <= state_nx;
      end
   end

   // counts din_late cycles spent in read_drive
   always_ff @(posedge clk20) begin
      if (reset || state != read_drive) begin
         settle_cnt <= '0;
      end else if (req.din_late && !settle_done) begin
         settle_cnt <= settle_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk20) begin
      if (reset) begin
         wr_stb <= 1'b0;
      end else begin
         wr_stb <= write_start;   // only on entry so one cycle
      end
   end

   // cleared between bus cycles
   always_ff @(posedge clk20) begin
      if (reset || !req.sync_s) begin
         wrote_q <= 1'b0;
      end else if (wr_stb) begin
         wrote_q <= 1'b1;
      end
   end

   // write payload valid with wr_stb
   always_ff @(posedge clk20) begin
      if (write_start) begin
         wr_index <= req.index;
         wr_data  <= dal_in[15:0];
      end
   end

   assign dal_tx   = (state == read_drive) || (state == read_reply);
   assign dal_st   = (state == read_reply);
   assign dal_be_l = (state != read_reply);      // active low
   assign trply    = (state == read_reply) || (state == write_reply);
   assign tdal     = dal_tx ? {6'b0, rd_word} : '0;   // words only with top bits zero

   // reply only inside an addressed cycle
   reply_hit: assert property (@(posedge clk20) disable iff (reset)
      trply |-> req.hit)
      else $error("trply raised outside a table hit");

   // a single one-cycle strobe per bus cycle
   strobe_one: assert property (@(posedge clk20) disable iff (reset)
      wr_stb |-> !wrote_q)
      else $error("more than one write strobe in a bus cycle");

endmodule

`default_nettype wire

// ==== qbus_decode.sv ====
/* strobes arrive asynchronous to clk20 and are seen two cycles late
   dal_in and bs7 must hold for 4 cycles after sync rises */
`default_nettype none

module qbus_decode import qsic_pkg::*; (
   input  logic     clk20,
   input  logic     reset,
   input  logic     sync,
   input  logic     din,
   input  logic     dout,
   input  logic     bs7,
   input  dal_t     dal_in,
   output bus_req_t req
);

   logic [1:0] sync_ra;    // 2-flop synchronizers
   logic [2:0] din_ra;     // extra stage makes din_late
   logic [1:0] dout_ra;
   logic       sync_d;     // previous sync_s, for edge detect
   logic       dout_d;
   logic       sync_s;
   logic       din_s;
   logic       dout_s;
   logic       sync_rise;
   logic       addr_match;
   logic       hit_q;
   logic [2:0] index_q;

   assign sync_s = sync_ra[1];
   assign din_s  = din_ra[1];
   assign dout_s = dout_ra[1];

   assign sync_rise = sync_s & ~sync_d;

   // eight words, so address bits 3..1 pick the entry; odd byte address never matches
   assign addr_match = bs7 && (dal_in[12:4] == table_base[12:4]) && !dal_in[0];

   always_ff @(posedge clk20) begin
      if (reset) begin
         sync_ra <= '0;
         din_ra  <= '0;
         dout_ra <= '0;
         sync_d  <= 1'b0;
         dout_d  <= 1'b0;
      end else begin
         sync_ra <= {sync_ra[0], sync};
         din_ra  <= {din_ra[1:0], din};
         dout_ra <= {dout_ra[0], dout};
         sync_d  <= sync_s;
         dout_d  <= dout_s;
      end
   end

   // address phase latch, held until sync goes away
   always_ff @(posedge clk20) begin
      if (reset) begin
         hit_q   <= 1'b0;
         index_q <= '0;
      end else if (sync_rise) begin
         hit_q   <= addr_match;
         index_q <= dal_in[3:1];   // word offset within the table
      end else if (!sync_s) begin
         hit_q   <= 1'b0;          // end of bus cycle
      end
   end

   always_comb begin
      req.hit       = hit_q;
      req.index     = index_q;
      req.sync_s    = sync_s;
      req.din_s     = din_s;
      req.dout_s    = dout_s;
      req.din_late  = din_ra[2] & din_ra[1];   // din stable for two samples
      req.dout_rise = dout_s & ~dout_d;
   end

   // a master never asserts both data strobes in one cycle
   strobe_excl: assert property (@(posedge clk20) disable iff (reset)
      !(din_s && dout_s))
      else $error("din and dout both asserted");

endmodule

`default_nettype wire

// ==== qsic_pkg.sv ====
/* shared types for the QBUS slave and the disk-pack load table
   table offsets count 8192-block units, so packs sit on 0x2000 boundaries */
`default_nettype none

package qsic_pkg;

   // bus and storage widths
   typedef logic [21:0] dal_t;       // data/address lines
   typedef logic [15:0] word_t;      // one bus word
   typedef logic [12:0] block_t;     // block within a pack
   typedef logic [31:0] lba_t;       // storage block address
   typedef logic [2:0]  dev_sel_t;   // drive select
   typedef logic [1:0]  device_t;    // storage device code

   localparam int n_packs = 8;       // drives, and load-table words

   // load table occupies 17700..17716 of the I/O page
   localparam logic [12:0] table_base = 13'o17700;

   // offset field is in units of 2**13 blocks
   localparam int offset_shift = 13;

   // one load-table word, bit 15 down to bit 0
   typedef struct packed {
      logic         enable;   // pack is enabled
      device_t      device;   // sd0, sd1, ramdisk, usb
      logic [12:0]  offset;   // pack start, 8192-block units
   } pack_entry_t;

   // decode side view of the current bus cycle
   typedef struct packed {
      logic         hit;        // address is a table word
      logic [2:0]   index;      // which table word
      logic         sync_s;     // synchronized strobes
      logic         din_s;
      logic         dout_s;
      logic         din_late;   // din held past the first cycle
      logic         dout_rise;  // first cycle of dout_s
   } bus_req_t;

endpackage

`default_nettype wire
